// File: Makefile
# Verilator build and regression run for the card-colour dealer.

VERILATOR ?= verilator
TOP       ?= deal_colors_tb
SEED      ?= 88
FILELIST  ?= deal_colors.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a listed source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) --top-module $(TOP) \
		-Gseed=$(SEED) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG) || \
		! grep -q "Regression passed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/deal_colors_tb.sv
`default_nettype none

module deal_colors_tb;

    import card_pkg::*;

    parameter int seed = 88;

    localparam int clk_half = 20;
    localparam int reset_cycles = 16;
    localparam int deals_per_size = 8;
    localparam int size_count = 4;
    // Longest idle gap that the stimulus can pick.
    localparam int max_gap = deals_per_size + 8 * 3;
    localparam int cycles_per_deal = 1 + reset_cycles + max_gap + 16 + 1;
    localparam int timeout_cycles = 2 + size_count * deals_per_size * cycles_per_deal + 200;

    logic                   clk;
    logic                   rst;
    logic                   enable;
    logic [card_addr_w-1:0] num_of_cards;
    card_data_t             card;
    logic [card_addr_w-1:0] card_address;
    logic                   done;

    bit   checks_on;
    int   errors = 0;
    int   deals_run = 0;
    rgb_t dealt [16];

    deal_colors uut (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .num_of_cards (num_of_cards),
        .card         (card),
        .card_address (card_address),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    // Deck sizes in the order they are dealt. Size 10 has no table.
    function automatic int deck_size(input int idx);
        case (idx)
            0:       return 8;
            1:       return 12;
            2:       return 16;
            default: return 10;
        endcase
    endfunction

    // Palette colours in the order the decks grow. The 8-card deck uses the first four.
    function automatic rgb_t palette_rgb(input int idx);
        case (idx)
            0:       return 12'hF00;
            1:       return 12'h0F0;
            2:       return 12'h00F;
            3:       return 12'hFF0;
            4:       return 12'h0FF;
            5:       return 12'hF0F;
            6:       return 12'hF82;
            7:       return 12'h802;
            default: return 12'hFFF;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks sampled at the rising edge
    ////////////////////////////////////////////////////////////

    reset_clears: assert property (@(posedge clk)
        checks_on && $past(rst) |-> card == '0 && card_address == '0)
        else report_fail("card word or address not cleared by reset");

    card_flags: assert property (@(posedge clk)
        checks_on && !$past(rst) |-> card.active && !card.discovered)
        else report_fail("card word has wrong active or discovered flag");

    address_steps: assert property (@(posedge clk)
        checks_on && !$past(rst) && $past(enable)
        |-> card_address == $past(card_address) + 1'b1)
        else report_fail("address did not step by one while dealing");

    idle_holds: assert property (@(posedge clk)
        checks_on && !$past(rst) && !$past(enable)
        |-> card_address == $past(card_address) && card.color == 12'h000)
        else report_fail("address moved or colour not black while idle");

    done_matches: assert property (@(posedge clk)
        checks_on |-> done == (card_address == num_of_cards - 5'd1))
        else report_fail("done does not match the last slot index");

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic apply_reset(input int n);
        @(negedge clk);
        rst = 1'b1;
        enable = 1'b0;
        num_of_cards = card_addr_w'(n);
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
    endtask

    // Each word shows up one clock after its enable edge, so it is read at the falling edge.
    task automatic run_deal(input int n, input int gap);
        apply_reset(n);
        repeat (gap) @(negedge clk);
        enable = 1'b1;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            dealt[i] = card.color;
            assert (card_address == card_addr_w'(i + 1))
                else report_fail($sformatf("entry %0d at address %0d", i, card_address));
            if (i == n - 1) begin
                enable = 1'b0;
            end
        end
        @(negedge clk);
        deals_run++;
    endtask

    task automatic check_palette(input int n);
        int count;
        int total;
        total = 0;
        for (int c = 0; c < n / 2; c++) begin
            count = 0;
            for (int i = 0; i < n; i++) begin
                if (dealt[i] == palette_rgb(c)) begin
                    count++;
                end
            end
            total += count;
            assert (count == 2)
                else report_fail($sformatf("deck %0d colour %0d seen %0d times", n, c, count));
        end
        assert (total == n)
            else report_fail($sformatf("deck %0d holds colours outside its palette", n));
    endtask

    task automatic check_black(input int n);
        for (int i = 0; i < n; i++) begin
            assert (dealt[i] == 12'h000)
                else report_fail($sformatf("deck %0d entry %0d is not black", n, i));
        end
    endtask

    initial begin
        int           size;
        int           gap;
        logic [191:0] first_layout;
        logic [191:0] layout_bits;
        bit           layouts_differ;
        rst = 1'b1;
        enable = 1'b0;
        num_of_cards = card_addr_w'(8);
        checks_on = 1'b0;
        void'($urandom(seed));
        repeat (2) @(negedge clk);
        checks_on = 1'b1;
        for (int s = 0; s < size_count; s++) begin
            size = deck_size(s);
            layouts_differ = 1'b0;
            first_layout = '0;
            for (int k = 0; k < deals_per_size; k++) begin
                // The k offset makes every deal of one size start on another version.
                gap = 1 + k + 8 * int'($urandom_range(0, 3));
                run_deal(size, gap);
                layout_bits = '0;
                for (int i = 0; i < size; i++) begin
                    layout_bits[i * 12 +: 12] = dealt[i];
                end
                if (size == 10) begin
                    check_black(size);
                end else begin
                    check_palette(size);
                    if (k == 0) begin
                        first_layout = layout_bits;
                    end else if (layout_bits != first_layout) begin
                        layouts_differ = 1'b1;
                    end
                end
            end
            if (size != 10) begin
                assert (layouts_differ)
                    else report_fail($sformatf("deck %0d gave one layout for all gaps", size));
            end
        end
        $display("Deals run: %0d, errors: %0d", deals_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(timeout_cycles * 2 * clk_half);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: deal_colors.f
design/card_pkg.sv
design/layout_rom.sv
design/deal_sequencer.sv
design/deal_colors.sv
bench/deal_colors_tb.sv

// File: design/card_pkg.sv
`default_nettype none

package card_pkg;

    ////////////////////////////////////////////////////////////
    // Board geometry
    ////////////////////////////////////////////////////////////

    // Slot addresses and the deck size share one width.
    parameter int card_addr_w = 5;

    // Number of shuffled layouts kept per deck size.
    parameter int version_count = 8;

    ////////////////////////////////////////////////////////////
    // Colours and card words
    ////////////////////////////////////////////////////////////

    // Layout tables store these codes. The RGB value is looked up afterwards.
    typedef enum logic [3:0] {
        red,
        green,
        blue,
        yellow,
        cyan,
        magenta,
        orange,
        purple,
        black,
        white
    } color_e;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Bit 0 is the active flag and bit 1 the discovered flag.
    typedef struct packed {
        rgb_t color;
        logic discovered;
        logic active;
    } card_data_t;

    // Palette shared by every layout.
    function automatic rgb_t color_rgb(input color_e code);
        rgb_t rgb;
        case (code)
            red:     rgb = 12'hF00;
            green:   rgb = 12'h0F0;
            blue:    rgb = 12'h00F;
            yellow:  rgb = 12'hFF0;
            cyan:    rgb = 12'h0FF;
            magenta: rgb = 12'hF0F;
            orange:  rgb = 12'hF82;
            purple:  rgb = 12'h802;
            white:   rgb = 12'hFFF;
            default: rgb = 12'h000;
        endcase
        return rgb;
    endfunction

endpackage

`default_nettype wire

// File: design/deal_colors.sv
`default_nettype none

module deal_colors #(
    parameter int addr_w = card_pkg::card_addr_w
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               enable,
    input  wire logic [card_pkg::card_addr_w-1:0]   num_of_cards,
    output card_pkg::card_data_t                    card,
    output logic [addr_w-1:0]                       card_address,
    output logic                                    done
);

    import card_pkg::*;

    logic [2:0]        version;
    logic [addr_w-1:0] entry;
    color_e            color;
    logic              supported;

    deal_sequencer #(
        .addr_w(addr_w)
    ) u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .num_of_cards (num_of_cards),
        .color        (color),
        .supported    (supported),
        .version      (version),
        .entry        (entry),
        .card         (card),
        .card_address (card_address),
        .done         (done)
    );

    layout_rom u_layout (
        .version      (version),
        .num_of_cards (num_of_cards),
        .entry        (entry),
        .color        (color),
        .supported    (supported)
    );

endmodule

`default_nettype wire

// File: design/deal_sequencer.sv
`default_nettype none

module deal_sequencer #(
    parameter int addr_w = card_pkg::card_addr_w
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               enable,
    input  wire logic [card_pkg::card_addr_w-1:0]   num_of_cards,
    input  wire card_pkg::color_e                   color,
    input  wire logic                               supported,
    output logic [2:0]                              version,
    output logic [addr_w-1:0]                       entry,
    output card_pkg::card_data_t                    card,
    output logic [addr_w-1:0]                       card_address,
    output logic                                    done
);

    import card_pkg::*;

    logic [2:0] version_next;
    rgb_t       rgb_next;

    ////////////////////////////////////////////////////////////
    // Layout version
    ////////////////////////////////////////////////////////////

    // Free-running while idle, so the wait before a game picks the layout.
    always_comb begin
        if (enable) begin
            version_next = version;
        end else if (version == 3'(version_count - 1)) begin
            version_next = '0;
        end else begin
            version_next = version + 3'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Slot walk and card word
    ////////////////////////////////////////////////////////////

    // The table is read at the current address, but the word lands together with
    // the incremented address. Slot 0 is kept for other game state.
    assign entry = card_address;

    always_comb begin
        if (enable && supported) begin
            rgb_next = color_rgb(color);
        end else begin
            rgb_next = color_rgb(black);
        end
    end

    // The address only returns to zero through reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            version      <= '0;
            card_address <= '0;
            card         <= '0;
        end else begin
            version <= version_next;
            if (enable) begin
                card_address <= card_address + addr_w'(1);
            end
            card <= '{color: rgb_next, discovered: 1'b0, active: 1'b1};
        end
    end

    // Done marks the last slot index of the deck.
    assign done = (card_address == addr_w'(num_of_cards - card_addr_w'(1)));

    // A dealing cycle must not disturb the chosen layout.
    a_version_holds: assert property (
        @(posedge clk) disable iff (rst)
        ($past(enable) && !$past(rst)) |-> (version == $past(version))
    ) else $error("deal_sequencer: version moved during a deal");

    // Every word after the reset cycle describes an active card.
    a_card_active: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> card.active
    ) else $error("deal_sequencer: inactive card word");

endmodule

`default_nettype wire

// File: design/layout_rom.sv
`default_nettype none

module layout_rom (
    input  wire logic [2:0]                         version,
    input  wire logic [card_pkg::card_addr_w-1:0]   num_of_cards,
    input  wire logic [card_pkg::card_addr_w-1:0]   entry,
    output card_pkg::color_e                        color,
    output logic                                    supported
);

    import card_pkg::*;

    ////////////////////////////////////////////////////////////
    // Layout tables, one row per version
    ////////////////////////////////////////////////////////////

    // Each row holds every colour of the deck's palette exactly twice.
    localparam color_e [0:7] deck8 [version_count] = '{
        '{green, blue, blue, red, green, yellow, yellow, red},
        '{red, green, yellow, blue, yellow, blue, green, red},
        '{blue, red, blue, red, green, yellow, yellow, green},
        '{red, red, blue, yellow, blue, green, green, yellow},
        '{green, red, blue, red, yellow, yellow, blue, green},
        '{green, yellow, green, red, blue, yellow, red, blue},
        '{blue, red, green, yellow, red, green, yellow, blue},
        '{blue, green, red, red, blue, green, yellow, yellow}
    };

    localparam color_e [0:11] deck12 [version_count] = '{
        '{yellow, red, blue, green, cyan, magenta,
          cyan, yellow, green, magenta, red, blue},
        '{red, green, blue, cyan, blue, red,
          yellow, magenta, cyan, magenta, yellow, green},
        '{yellow, cyan, green, blue, yellow, blue,
          magenta, magenta, cyan, red, green, red},
        '{blue, magenta, blue, green, red, cyan,
          green, cyan, magenta, red, yellow, yellow},
        '{magenta, cyan, yellow, magenta, green, blue,
          green, yellow, red, cyan, red, blue},
        '{green, cyan, green, magenta, yellow, cyan,
          red, red, blue, yellow, magenta, blue},
        '{magenta, green, blue, blue, green, red,
          red, yellow, cyan, magenta, cyan, yellow},
        '{green, red, magenta, yellow, red, cyan,
          yellow, green, blue, magenta, cyan, blue}
    };

    localparam color_e [0:15] deck16 [version_count] = '{
        '{orange, magenta, cyan, green, purple, red, yellow, cyan,
          green, blue, red, orange, magenta, blue, purple, yellow},
        '{magenta, red, orange, cyan, green, yellow, magenta, orange,
          green, cyan, yellow, purple, purple, blue, red, blue},
        '{purple, yellow, red, magenta, magenta, yellow, purple, green,
          cyan, blue, blue, orange, red, green, cyan, orange},
        '{magenta, cyan, orange, orange, purple, blue, blue, cyan,
          purple, green, red, yellow, yellow, green, red, magenta},
        '{purple, orange, blue, magenta, green, purple, red, cyan,
          yellow, orange, red, green, blue, cyan, yellow, magenta},
        '{red, magenta, orange, green, yellow, cyan, cyan, purple,
          purple, blue, magenta, blue, green, yellow, red, orange},
        '{orange, red, orange, purple, yellow, blue, magenta, green,
          cyan, green, red, cyan, blue, magenta, yellow, purple},
        '{blue, purple, cyan, cyan, yellow, red, yellow, green,
          magenta, blue, green, magenta, orange, purple, orange, red}
    };

    ////////////////////////////////////////////////////////////
    // Entry selection
    ////////////////////////////////////////////////////////////

    // Entries past the end of a known deck read as white.
    always_comb begin
        supported = 1'b1;
        color     = white;
        case (num_of_cards)
            card_addr_w'(8): begin
                if (entry < card_addr_w'(8)) begin
                    color = deck8[version][entry[2:0]];
                end
            end
            card_addr_w'(12): begin
                if (entry < card_addr_w'(12)) begin
                    color = deck12[version][entry[3:0]];
                end
            end
            card_addr_w'(16): begin
                if (entry < card_addr_w'(16)) begin
                    color = deck16[version][entry[3:0]];
                end
            end
            default: begin
                supported = 1'b0;
                color     = black;
            end
        endcase
    end

    // Known inputs must always resolve to a defined code.
    always_comb begin
        if (!$isunknown({version, num_of_cards, entry})) begin
            assert (!$isunknown({color, supported}))
                else $error("layout_rom: unknown colour for known inputs");
        end
    end

endmodule

`default_nettype wire
